//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int XLEN = 32;

  typedef logic [4:0] reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  // major opcodes, bits 6:0 of every word
  typedef enum logic [6:0] {
    LOAD     = 7'b000_0011,
    LOAD_FP  = 7'b000_0111,
    MISCMEM  = 7'b000_1111,
    IMMED    = 7'b001_0011,
    AUIPC    = 7'b001_0111,
    STORE    = 7'b010_0011,
    STORE_FP = 7'b010_0111,
    REGREG   = 7'b011_0011,
    LUI      = 7'b011_0111,
    VECTOR   = 7'b101_0111,
    BRANCH   = 7'b110_0011,
    JALR     = 7'b110_0111,
    JAL      = 7'b110_1111,
    SYSTEM   = 7'b111_0011
  } opcode_t;

  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } imm_funct3_t;

  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } regreg_funct3_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    PRIV   = 3'b000,
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } system_funct3_t;

  typedef enum logic [2:0] {
    FENCE  = 3'b000,
    FENCEI = 3'b001
  } miscmem_funct3_t;

  // funct12 field of PRIV words
  typedef enum logic [11:0] {
    ECALL  = 12'h000,
    EBREAK = 12'h001,
    WFI    = 12'h105,
    MRET   = 12'h302
  } priv_insn_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } btype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    reg_idx_t    rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_idx_t   rd;
    opcode_t    opcode;
  } jtype_t;

  // one fetched word, viewed in whichever format the opcode calls for
  typedef union packed {
    rtype_t      r;
    itype_t      i;
    stype_t      s;
    btype_t      b;
    utype_t      u;
    jtype_t      j;
    logic [31:0] raw;
  } instr_u;

endpackage

`default_nettype wire

//--- logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SRL  = 4'd3,
    SRA  = 4'd4,
    AND  = 4'd5,
    OR   = 4'd6,
    XOR  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_t;

  // which execution unit takes the word
  typedef enum logic [1:0] {
    ARITH     = 2'd0,
    LOADSTORE = 2'd1,
    MUL       = 2'd2,
    DIV       = 2'd3
  } fu_t;

  // register file write-back mux
  typedef enum logic [2:0] {
    LOAD_SRC = 3'd0,
    JUMP_SRC = 3'd1,
    LUI_SRC  = 3'd2,
    ALU_SRC  = 3'd3,
    CSR_SRC  = 3'd4
  } wsrc_t;

  typedef enum logic [1:0] {
    SIGNED          = 2'd0,
    UNSIGNED        = 2'd1,
    SIGNED_UNSIGNED = 2'd2
  } sign_t;

  typedef struct packed {
    isa_pkg::reg_idx_t          rs1;
    isa_pkg::reg_idx_t          rs2;
    isa_pkg::reg_idx_t          rd;
    logic [isa_pkg::XLEN-1:0]   imm_i;
    logic [isa_pkg::XLEN-1:0]   imm_s;
    logic [isa_pkg::XLEN-1:0]   imm_b;
    logic [isa_pkg::XLEN-1:0]   imm_j;
    logic [isa_pkg::XLEN-1:0]   imm_u;
  } imm_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    imm_shamt_sel;
    logic    mul_high;
    sign_t   muldiv_sign;
    logic    div_quotient;
  } arith_ctrl_t;

  typedef struct packed {
    logic                     csr_swap;
    logic                     csr_set;
    logic                     csr_clr;
    logic                     csr_imm;
    logic                     csr_rw_valid;
    isa_pkg::csr_addr_t       csr_addr;
    logic [isa_pkg::XLEN-1:0] csr_zimm;
    logic                     ret;
    logic                     breakpoint;
    logic                     ecall;
    logic                     wfi;
  } sys_ctrl_t;

  typedef struct packed {
    logic             wen;
    wsrc_t            w_src;
    logic [1:0]       source_a_sel;
    logic [1:0]       source_b_sel;
    fu_t              fu;
    logic             dren;
    logic             dwen;
    isa_pkg::load_t   load_type;
    logic             branch;
    isa_pkg::branch_t branch_type;
    logic             jump;
    logic             j_sel;
    logic             lui;
    logic             ifence;
    logic             illegal;
  } flow_ctrl_t;

  // full result presented by the decoder
  typedef struct packed {
    flow_ctrl_t  flow;
    imm_t        imm;
    arith_ctrl_t arith;
    sys_ctrl_t   sys;
  } decoded_t;

endpackage

`default_nettype wire

//--- logic/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
  input  wire isa_pkg::instr_u instr_i,
  output decode_pkg::imm_t     imm_o
);

  localparam int W = isa_pkg::XLEN;

  isa_pkg::itype_t i_f;
  isa_pkg::stype_t s_f;
  isa_pkg::btype_t b_f;
  isa_pkg::jtype_t j_f;
  isa_pkg::utype_t u_f;

  assign i_f = instr_i.i;
  assign s_f = instr_i.s;
  assign b_f = instr_i.b;
  assign j_f = instr_i.j;
  assign u_f = instr_i.u;

  // index fields sit at the same bits in every format
  assign imm_o.rs1 = instr_i.r.rs1;
  assign imm_o.rs2 = instr_i.r.rs2;
  assign imm_o.rd  = instr_i.r.rd;

  assign imm_o.imm_i = {{(W-12){i_f.imm11_00[11]}}, i_f.imm11_00};
  assign imm_o.imm_s = {{(W-12){s_f.imm11_05[6]}}, s_f.imm11_05, s_f.imm04_00};

  // branch and jump offsets are halfword aligned
  assign imm_o.imm_b = {{(W-13){b_f.imm12}}, b_f.imm12, b_f.imm11,
                        b_f.imm10_05, b_f.imm04_01, 1'b0};
  assign imm_o.imm_j = {{(W-21){j_f.imm20}}, j_f.imm20, j_f.imm19_12,
                        j_f.imm11, j_f.imm10_01, 1'b0};

  assign imm_o.imm_u = {u_f.imm31_12, 12'b0};

endmodule

`default_nettype wire

//--- logic/arith_decode.sv
`timescale 1ns/10ps
`default_nettype none

module arith_decode (
  input  wire isa_pkg::instr_u  instr_i,
  output decode_pkg::arith_ctrl_t arith_o
);

  isa_pkg::opcode_t        opcode;
  isa_pkg::imm_funct3_t    f3_imm;
  isa_pkg::regreg_funct3_t f3_reg;
  logic                    is_imm;
  logic                    is_reg;
  logic                    shift_r;
  logic                    add_sub;
  logic                    op_sll, op_sra, op_srl, op_add, op_sub;
  logic                    op_and, op_or, op_xor, op_slt, op_sltu;
  logic                    div_word;
  decode_pkg::alu_op_t     alu_op;
  decode_pkg::sign_t       sign;

  assign opcode = instr_i.r.opcode;
  assign f3_imm = isa_pkg::imm_funct3_t'(instr_i.i.funct3);
  assign f3_reg = isa_pkg::regreg_funct3_t'(instr_i.r.funct3);
  assign is_imm = (opcode == isa_pkg::IMMED);
  assign is_reg = (opcode == isa_pkg::REGREG);

  // bit 30 picks arithmetic shift and subtract
  assign shift_r = (is_imm && f3_imm == isa_pkg::SRI) || (is_reg && f3_reg == isa_pkg::SR);
  assign add_sub = is_reg && f3_reg == isa_pkg::ADDSUB;

  assign op_sll  = (is_imm && f3_imm == isa_pkg::SLLI) || (is_reg && f3_reg == isa_pkg::SLL);
  assign op_sra  = shift_r && instr_i.raw[30];
  assign op_srl  = shift_r && !instr_i.raw[30];
  assign op_add  = (is_imm && f3_imm == isa_pkg::ADDI) || (add_sub && !instr_i.raw[30]) ||
                   (opcode == isa_pkg::AUIPC) || (opcode == isa_pkg::LOAD) ||
                   (opcode == isa_pkg::STORE);
  assign op_sub  = add_sub && instr_i.raw[30];
  assign op_and  = (is_imm && f3_imm == isa_pkg::ANDI) || (is_reg && f3_reg == isa_pkg::AND);
  assign op_or   = (is_imm && f3_imm == isa_pkg::ORI) || (is_reg && f3_reg == isa_pkg::OR);
  assign op_xor  = (is_imm && f3_imm == isa_pkg::XORI) || (is_reg && f3_reg == isa_pkg::XOR);
  assign op_slt  = (is_imm && f3_imm == isa_pkg::SLTI) || (is_reg && f3_reg == isa_pkg::SLT);
  assign op_sltu = (is_imm && f3_imm == isa_pkg::SLTIU) || (is_reg && f3_reg == isa_pkg::SLTU);

  always_comb begin
    if (op_sll)       alu_op = decode_pkg::SLL;
    else if (op_sra)  alu_op = decode_pkg::SRA;
    else if (op_srl)  alu_op = decode_pkg::SRL;
    else if (op_add)  alu_op = decode_pkg::ADD;
    else if (op_sub)  alu_op = decode_pkg::SUB;
    else if (op_and)  alu_op = decode_pkg::AND;
    else if (op_or)   alu_op = decode_pkg::OR;
    else if (op_xor)  alu_op = decode_pkg::XOR;
    else if (op_slt)  alu_op = decode_pkg::SLT;
    else if (op_sltu) alu_op = decode_pkg::SLTU;
    else              alu_op = decode_pkg::ADD;
  end

  // mulhu, divu, remu are unsigned; mulhsu mixes
  always_comb begin
    case (instr_i.r.funct3)
      3'b011, 3'b101, 3'b111: sign = decode_pkg::UNSIGNED;
      3'b010:                 sign = decode_pkg::SIGNED_UNSIGNED;
      default:                sign = decode_pkg::SIGNED;
    endcase
  end

  assign div_word = is_reg && (instr_i.r.funct7 == 7'b000_0001) && instr_i.r.funct3[2];

  assign arith_o.alu_op        = alu_op;
  assign arith_o.imm_shamt_sel = is_imm && (f3_imm == isa_pkg::SLLI || f3_imm == isa_pkg::SRI);
  assign arith_o.mul_high      = |instr_i.r.funct3[1:0];
  assign arith_o.muldiv_sign   = sign;
  assign arith_o.div_quotient  = div_word && !instr_i.r.funct3[1];

endmodule

`default_nettype wire

//--- logic/system_decode.sv
`timescale 1ns/10ps
`default_nettype none

module system_decode (
  input  wire isa_pkg::instr_u  instr_i,
  output decode_pkg::sys_ctrl_t sys_o
);

  logic                       is_sys;
  isa_pkg::system_funct3_t    f3;
  isa_pkg::priv_insn_t        funct12;
  logic                       swap, set, clr, use_imm;
  logic                       ret, brk, ecall, wfi;

  assign is_sys  = (instr_i.i.opcode == isa_pkg::SYSTEM);
  assign f3      = isa_pkg::system_funct3_t'(instr_i.i.funct3);
  assign funct12 = isa_pkg::priv_insn_t'(instr_i.i.imm11_00);

  // immediate forms share the flag of their register form
  always_comb begin
    swap    = 1'b0;
    set     = 1'b0;
    clr     = 1'b0;
    use_imm = 1'b0;
    if (is_sys) begin
      case (f3)
        isa_pkg::CSRRW:  swap = 1'b1;
        isa_pkg::CSRRS:  set  = 1'b1;
        isa_pkg::CSRRC:  clr  = 1'b1;
        isa_pkg::CSRRWI: begin
          swap    = 1'b1;
          use_imm = 1'b1;
        end
        isa_pkg::CSRRSI: begin
          set     = 1'b1;
          use_imm = 1'b1;
        end
        isa_pkg::CSRRCI: begin
          clr     = 1'b1;
          use_imm = 1'b1;
        end
        default: ;
      endcase
    end
  end

  // privileged words carry their identity in funct12
  always_comb begin
    ret   = 1'b0;
    brk   = 1'b0;
    ecall = 1'b0;
    wfi   = 1'b0;
    if (is_sys && f3 == isa_pkg::PRIV) begin
      ret   = (funct12 == isa_pkg::MRET);
      brk   = (funct12 == isa_pkg::EBREAK);
      ecall = (funct12 == isa_pkg::ECALL);
      wfi   = (funct12 == isa_pkg::WFI);
    end
  end

  assign sys_o.csr_swap     = swap;
  assign sys_o.csr_set      = set;
  assign sys_o.csr_clr      = clr;
  assign sys_o.csr_imm      = use_imm;
  assign sys_o.csr_rw_valid = swap | set | clr;
  assign sys_o.csr_addr     = isa_pkg::csr_addr_t'(instr_i.i.imm11_00);
  // uimm5 rides in the rs1 field
  assign sys_o.csr_zimm     = is_sys ? {{(isa_pkg::XLEN-5){1'b0}}, instr_i.i.rs1} : '0;
  assign sys_o.ret          = ret;
  assign sys_o.breakpoint   = brk;
  assign sys_o.ecall        = ecall;
  assign sys_o.wfi          = wfi;

endmodule

`default_nettype wire

//--- logic/decode_control.sv
`timescale 1ns/10ps
`default_nettype none

module decode_control #(
  parameter bit MULDIV_EN = 1'b1
) (
  input  wire isa_pkg::instr_u     instr_i,
  input  wire logic                csr_rw_valid_i,
  output decode_pkg::flow_ctrl_t   flow_o
);

  isa_pkg::opcode_t  opcode;
  logic [2:0]        funct3;
  logic              m_encoding;
  logic              m_accepted;
  logic              wen;
  decode_pkg::wsrc_t w_src;
  logic [1:0]        a_sel;
  logic [1:0]        b_sel;
  decode_pkg::fu_t   fu;
  logic              illegal;

  assign opcode = instr_i.r.opcode;
  assign funct3 = instr_i.r.funct3;

  // funct7 of 1 marks the M extension
  assign m_encoding = (opcode == isa_pkg::REGREG) && (instr_i.r.funct7 == 7'b000_0001);
  assign m_accepted = MULDIV_EN && m_encoding;

  always_comb begin
    case (opcode)
      isa_pkg::LOAD:                                 w_src = decode_pkg::LOAD_SRC;
      isa_pkg::JAL, isa_pkg::JALR:                   w_src = decode_pkg::JUMP_SRC;
      isa_pkg::LUI:                                  w_src = decode_pkg::LUI_SRC;
      isa_pkg::IMMED, isa_pkg::AUIPC, isa_pkg::REGREG: w_src = decode_pkg::ALU_SRC;
      isa_pkg::SYSTEM:                               w_src = decode_pkg::CSR_SRC;
      default:                                       w_src = decode_pkg::LOAD_SRC;
    endcase
  end

  always_comb begin
    case (opcode)
      isa_pkg::IMMED, isa_pkg::LUI, isa_pkg::AUIPC, isa_pkg::REGREG,
      isa_pkg::JAL, isa_pkg::JALR, isa_pkg::LOAD: wen = 1'b1;
      // only real CSR accesses write rd
      isa_pkg::SYSTEM: wen = csr_rw_valid_i;
      default:         wen = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      isa_pkg::REGREG, isa_pkg::IMMED, isa_pkg::LOAD,
      isa_pkg::BRANCH, isa_pkg::JALR, isa_pkg::SYSTEM: a_sel = 2'd0;
      isa_pkg::STORE:                                  a_sel = 2'd1;
      default:                                         a_sel = 2'd2;
    endcase
  end

  always_comb begin
    case (opcode)
      isa_pkg::STORE:                b_sel = 2'd0;
      isa_pkg::REGREG:               b_sel = 2'd1;
      isa_pkg::IMMED, isa_pkg::LOAD: b_sel = 2'd2;
      isa_pkg::AUIPC:                b_sel = 2'd3;
      default:                       b_sel = 2'd1;
    endcase
  end

  // bit 2 of funct3 splits mul from div/rem
  always_comb begin
    if (m_accepted) begin
      fu = funct3[2] ? decode_pkg::DIV : decode_pkg::MUL;
    end else if (opcode == isa_pkg::LOAD || opcode == isa_pkg::STORE) begin
      fu = decode_pkg::LOADSTORE;
    end else begin
      fu = decode_pkg::ARITH;
    end
  end

  always_comb begin
    case (opcode)
      isa_pkg::REGREG: illegal = instr_i.r.funct7[0] && !m_accepted;
      isa_pkg::LUI, isa_pkg::AUIPC, isa_pkg::JAL, isa_pkg::JALR,
      isa_pkg::BRANCH, isa_pkg::LOAD, isa_pkg::STORE, isa_pkg::IMMED,
      isa_pkg::SYSTEM, isa_pkg::MISCMEM, isa_pkg::opcode_t'(7'b0): illegal = 1'b0;
      // fp and vector opcodes land here too
      default: illegal = 1'b1;
    endcase
  end

  assign flow_o.wen          = wen;
  assign flow_o.w_src        = w_src;
  assign flow_o.source_a_sel = a_sel;
  assign flow_o.source_b_sel = b_sel;
  assign flow_o.fu           = fu;
  assign flow_o.dren         = (opcode == isa_pkg::LOAD);
  assign flow_o.dwen         = (opcode == isa_pkg::STORE);
  assign flow_o.load_type    = isa_pkg::load_t'(instr_i.i.funct3);
  assign flow_o.branch       = (opcode == isa_pkg::BRANCH);
  assign flow_o.branch_type  = isa_pkg::branch_t'(instr_i.b.funct3);
  assign flow_o.jump         = (opcode == isa_pkg::JAL) || (opcode == isa_pkg::JALR);
  assign flow_o.j_sel        = (opcode == isa_pkg::JAL);
  assign flow_o.lui          = (opcode == isa_pkg::LUI);
  assign flow_o.ifence       = (opcode == isa_pkg::MISCMEM) &&
                               (isa_pkg::miscmem_funct3_t'(funct3) == isa_pkg::FENCEI);
  assign flow_o.illegal      = illegal;

endmodule

`default_nettype wire

//--- logic/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder #(
  parameter bit MULDIV_EN = 1'b1
) (
  input  wire logic             clk,
  input  wire logic             reset_i,
  input  wire logic             instr_valid_i,
  input  wire isa_pkg::instr_u  instr_i,
  output logic                  decoded_valid_o,
  output decode_pkg::decoded_t  decoded_o
);

  decode_pkg::flow_ctrl_t  flow;
  decode_pkg::imm_t        imm;
  decode_pkg::arith_ctrl_t arith;
  decode_pkg::sys_ctrl_t   sys;
  decode_pkg::decoded_t    decoded_next;

  imm_gen u_imm_gen (
    .instr_i (instr_i),
    .imm_o   (imm)
  );

  arith_decode u_arith_decode (
    .instr_i (instr_i),
    .arith_o (arith)
  );

  system_decode u_system_decode (
    .instr_i (instr_i),
    .sys_o   (sys)
  );

  // SYSTEM write enable follows the csr access flag
  decode_control #(
    .MULDIV_EN (MULDIV_EN)
  ) u_decode_control (
    .instr_i        (instr_i),
    .csr_rw_valid_i (sys.csr_rw_valid),
    .flow_o         (flow)
  );

  assign decoded_next = '{flow: flow, imm: imm, arith: arith, sys: sys};

  // one stage; payload only loads on a valid word
  always_ff @(posedge clk) begin
    if (reset_i) begin
      decoded_valid_o <= 1'b0;
      decoded_o       <= '0;
    end else begin
      decoded_valid_o <= instr_valid_i;
      if (instr_valid_i) begin
        decoded_o <= decoded_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected bundle for one word, MULDIV_EN assumed set
function automatic decode_pkg::decoded_t model_decode(input logic [31:0] w);
  decode_pkg::decoded_t d;
  logic [6:0]           op;
  logic [2:0]           f3;
  logic                 m_word;
  d      = '0;
  op     = w[6:0];
  f3     = w[14:12];
  m_word = (op == isa_pkg::REGREG) && (w[31:25] == 7'h01);

  d.imm.rs1   = w[19:15];
  d.imm.rs2   = w[24:20];
  d.imm.rd    = w[11:7];
  d.imm.imm_i = {{20{w[31]}}, w[31:20]};
  d.imm.imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
  d.imm.imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  d.imm.imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  d.imm.imm_u = {w[31:12], 12'h000};

  // alu op by funct3, bit 30 for sra and sub
  d.arith.alu_op = decode_pkg::ADD;
  if (op == isa_pkg::IMMED || op == isa_pkg::REGREG) begin
    case (f3)
      3'b000: d.arith.alu_op = (op == isa_pkg::REGREG && w[30]) ? decode_pkg::SUB
                                                               : decode_pkg::ADD;
      3'b001: d.arith.alu_op = decode_pkg::SLL;
      3'b010: d.arith.alu_op = decode_pkg::SLT;
      3'b011: d.arith.alu_op = decode_pkg::SLTU;
      3'b100: d.arith.alu_op = decode_pkg::XOR;
      3'b101: d.arith.alu_op = w[30] ? decode_pkg::SRA : decode_pkg::SRL;
      3'b110: d.arith.alu_op = decode_pkg::OR;
      default: d.arith.alu_op = decode_pkg::AND;
    endcase
  end
  d.arith.imm_shamt_sel = (op == isa_pkg::IMMED) && (f3 == 3'b001 || f3 == 3'b101);
  d.arith.mul_high      = f3[1] | f3[0];
  case (f3)
    3'b011, 3'b101, 3'b111: d.arith.muldiv_sign = decode_pkg::UNSIGNED;
    3'b010:                 d.arith.muldiv_sign = decode_pkg::SIGNED_UNSIGNED;
    default:                d.arith.muldiv_sign = decode_pkg::SIGNED;
  endcase
  d.arith.div_quotient = m_word && f3[2] && !f3[1];

  d.sys.csr_addr = w[31:20];
  if (op == isa_pkg::SYSTEM) begin
    d.sys.csr_zimm = {27'b0, w[19:15]};
    d.sys.csr_swap = (f3 == 3'b001) || (f3 == 3'b101);
    d.sys.csr_set  = (f3 == 3'b010) || (f3 == 3'b110);
    d.sys.csr_clr  = (f3 == 3'b011) || (f3 == 3'b111);
    d.sys.csr_imm  = f3[2] && (f3[1:0] != 2'b00);
    if (f3 == 3'b000) begin
      d.sys.ret        = (w[31:20] == isa_pkg::MRET);
      d.sys.breakpoint = (w[31:20] == isa_pkg::EBREAK);
      d.sys.ecall      = (w[31:20] == isa_pkg::ECALL);
      d.sys.wfi        = (w[31:20] == isa_pkg::WFI);
    end
  end
  d.sys.csr_rw_valid = d.sys.csr_swap | d.sys.csr_set | d.sys.csr_clr;

  // defaults for opcodes without their own row
  d.flow.load_type    = isa_pkg::load_t'(f3);
  d.flow.branch_type  = isa_pkg::branch_t'(f3);
  d.flow.source_a_sel = 2'd2;
  d.flow.source_b_sel = 2'd1;
  d.flow.illegal      = 1'b1;
  case (op)
    7'h00: d.flow.illegal = 1'b0;
    isa_pkg::LOAD: begin
      d.flow.wen          = 1'b1;
      d.flow.source_a_sel = 2'd0;
      d.flow.source_b_sel = 2'd2;
      d.flow.fu           = decode_pkg::LOADSTORE;
      d.flow.dren         = 1'b1;
      d.flow.illegal      = 1'b0;
    end
    isa_pkg::MISCMEM: begin
      d.flow.ifence  = (f3 == 3'b001);
      d.flow.illegal = 1'b0;
    end
    isa_pkg::IMMED: begin
      d.flow.wen          = 1'b1;
      d.flow.w_src        = decode_pkg::ALU_SRC;
      d.flow.source_a_sel = 2'd0;
      d.flow.source_b_sel = 2'd2;
      d.flow.illegal      = 1'b0;
    end
    isa_pkg::AUIPC: begin
      d.flow.wen          = 1'b1;
      d.flow.w_src        = decode_pkg::ALU_SRC;
      d.flow.source_b_sel = 2'd3;
      d.flow.illegal      = 1'b0;
    end
    isa_pkg::STORE: begin
      d.flow.source_a_sel = 2'd1;
      d.flow.source_b_sel = 2'd0;
      d.flow.fu           = decode_pkg::LOADSTORE;
      d.flow.dwen         = 1'b1;
      d.flow.illegal      = 1'b0;
    end
    isa_pkg::REGREG: begin
      d.flow.wen          = 1'b1;
      d.flow.w_src        = decode_pkg::ALU_SRC;
      d.flow.source_a_sel = 2'd0;
      if (m_word) begin
        d.flow.fu = f3[2] ? decode_pkg::DIV : decode_pkg::MUL;
      end
      d.flow.illegal = w[25] && !m_word;
    end
    isa_pkg::LUI: begin
      d.flow.wen     = 1'b1;
      d.flow.w_src   = decode_pkg::LUI_SRC;
      d.flow.lui     = 1'b1;
      d.flow.illegal = 1'b0;
    end
    isa_pkg::BRANCH: begin
      d.flow.source_a_sel = 2'd0;
      d.flow.branch       = 1'b1;
      d.flow.illegal      = 1'b0;
    end
    isa_pkg::JALR: begin
      d.flow.wen          = 1'b1;
      d.flow.w_src        = decode_pkg::JUMP_SRC;
      d.flow.source_a_sel = 2'd0;
      d.flow.jump         = 1'b1;
      d.flow.illegal      = 1'b0;
    end
    isa_pkg::JAL: begin
      d.flow.wen     = 1'b1;
      d.flow.w_src   = decode_pkg::JUMP_SRC;
      d.flow.jump    = 1'b1;
      d.flow.j_sel   = 1'b1;
      d.flow.illegal = 1'b0;
    end
    isa_pkg::SYSTEM: begin
      d.flow.wen          = d.sys.csr_rw_valid;
      d.flow.w_src        = decode_pkg::CSR_SRC;
      d.flow.source_a_sel = 2'd0;
      d.flow.illegal      = 1'b0;
    end
    default: ;
  endcase
  return d;
endfunction

`endif

//--- bench/tb_instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_instr_decoder;

  localparam int          NUM_WORDS   = 2000;
  localparam int          CYCLE_LIMIT = NUM_WORDS + 50;
  localparam logic [31:0] SEED        = 32'h8eb39a0b;

  localparam logic [6:0] LEGAL_OPS [11] = '{
    isa_pkg::LOAD, isa_pkg::MISCMEM, isa_pkg::IMMED, isa_pkg::AUIPC, isa_pkg::STORE,
    isa_pkg::REGREG, isa_pkg::LUI, isa_pkg::BRANCH, isa_pkg::JALR, isa_pkg::JAL,
    isa_pkg::SYSTEM
  };
  // base, alternate (sub/sra) and M extension
  localparam logic [6:0] REG_F7 [3] = '{7'h00, 7'h20, 7'h01};

  logic                 clk;
  logic                 reset_i;
  logic                 instr_valid_i;
  isa_pkg::instr_u      instr_i;
  logic                 decoded_valid_o;
  decode_pkg::decoded_t decoded_o;

  decode_pkg::decoded_t exp_q[$];
  logic                 valid_q[$];
  string                name_q[$];
  logic [31:0]          directed_q[$];
  int                   checks = 0;
  int                   errors = 0;
  int                   cycle_count = 0;

  `include "decode_model.svh"

  instr_decoder #(
    .MULDIV_EN (1'b1)
  ) DUT (
    .clk             (clk),
    .reset_i         (reset_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .decoded_valid_o (decoded_valid_o),
    .decoded_o       (decoded_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("ERROR: timeout, stimulus still running after %0d cycles", cycle_count);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [191:0] expected,
                             input logic [191:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // oldest expectation against what the output register holds now
  task automatic compare_outputs();
    decode_pkg::decoded_t exp_d;
    logic                 exp_v;
    string                name;
    exp_d = exp_q.pop_front();
    exp_v = valid_q.pop_front();
    name  = name_q.pop_front();
    check_value($sformatf("%s valid", name), 192'(exp_v), 192'(decoded_valid_o));
    check_value($sformatf("%s flow", name), 192'(exp_d.flow), 192'(decoded_o.flow));
    check_value($sformatf("%s imm", name), 192'(exp_d.imm), 192'(decoded_o.imm));
    check_value($sformatf("%s arith", name), 192'(exp_d.arith), 192'(decoded_o.arith));
    check_value($sformatf("%s sys", name), 192'(exp_d.sys), 192'(decoded_o.sys));
  endtask

  function automatic logic [31:0] with_opcode(input logic [31:0] w, input logic [6:0] op);
    return {w[31:7], op};
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = $urandom;
    if ($urandom_range(99) < 15) begin
      return w;
    end
    w[6:0] = LEGAL_OPS[4'($urandom_range(10))];
    if (w[6:0] == isa_pkg::REGREG) begin
      w[31:25] = REG_F7[2'($urandom_range(2))];
    end
    return w;
  endfunction

  task automatic build_directed();
    logic [31:0] w;
    // every system funct3, csr forms and the unused ones
    for (int k = 0; k < 8; k++) begin
      w        = $urandom;
      w[14:12] = 3'(k);
      directed_q.push_back(with_opcode(w, isa_pkg::SYSTEM));
    end
    directed_q.push_back({isa_pkg::MRET, 13'b0, isa_pkg::SYSTEM});
    directed_q.push_back({isa_pkg::EBREAK, 13'b0, isa_pkg::SYSTEM});
    directed_q.push_back({isa_pkg::ECALL, 13'b0, isa_pkg::SYSTEM});
    directed_q.push_back({isa_pkg::WFI, 13'b0, isa_pkg::SYSTEM});
    // mul/div words then odd funct7 that is not M
    for (int k = 0; k < 8; k++) begin
      w        = $urandom;
      w[31:25] = 7'h01;
      w[14:12] = 3'(k);
      directed_q.push_back(with_opcode(w, isa_pkg::REGREG));
    end
    for (int k = 0; k < 4; k++) begin
      w        = $urandom;
      w[31:25] = 7'(2 * $urandom_range(63, 1) + 1);
      directed_q.push_back(with_opcode(w, isa_pkg::REGREG));
    end
    directed_q.push_back(with_opcode($urandom, isa_pkg::LOAD_FP));
    directed_q.push_back(with_opcode($urandom, isa_pkg::STORE_FP));
    directed_q.push_back(with_opcode($urandom, isa_pkg::VECTOR));
    w        = $urandom;
    w[14:12] = 3'b001;
    directed_q.push_back(with_opcode(w, isa_pkg::MISCMEM));
    w[14:12] = 3'b000;
    directed_q.push_back(with_opcode(w, isa_pkg::MISCMEM));
    // negative branch and jump offsets
    w     = $urandom;
    w[31] = 1'b1;
    directed_q.push_back(with_opcode(w, isa_pkg::BRANCH));
    directed_q.push_back(with_opcode(w, isa_pkg::JAL));
  endtask

  initial begin
    logic [31:0]          word;
    logic                 valid;
    decode_pkg::decoded_t held;
    void'($urandom(SEED));
    reset_i       = 1'b1;
    // a valid word during reset must not reach the output
    instr_valid_i = 1'b1;
    instr_i.raw   = {20'hfffff, 5'd1, isa_pkg::LUI};
    held          = '0;
    build_directed();

    // output register must come out of reset cleared
    exp_q.push_back('0);
    valid_q.push_back(1'b0);
    name_q.push_back("during reset");
    repeat (2) @(posedge clk);
    reset_i       <= 1'b0;
    instr_valid_i <= 1'b0;
    @(negedge clk);
    compare_outputs();
    exp_q.push_back('0);
    valid_q.push_back(1'b0);
    name_q.push_back("after reset");

    for (int n = 0; n < NUM_WORDS; n++) begin
      if (n < directed_q.size()) begin
        word  = directed_q[n];
        valid = 1'b1;
      end else begin
        word  = random_word();
        valid = ($urandom_range(99) < 80);
      end
      @(posedge clk);
      instr_valid_i <= valid;
      instr_i.raw   <= word;
      @(negedge clk);
      compare_outputs();
      // payload holds its last value while valid is low
      if (valid) begin
        held = model_decode(word);
      end
      exp_q.push_back(held);
      valid_q.push_back(valid);
      name_q.push_back($sformatf("word %0d %h", n, word));
    end
    @(posedge clk);
    instr_valid_i <= 1'b0;
    @(negedge clk);
    compare_outputs();

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+bench
logic/isa_pkg.sv
logic/decode_pkg.sv
logic/imm_gen.sv
logic/arith_decode.sv
logic/system_decode.sv
logic/decode_control.sv
logic/instr_decoder.sv
bench/tb_instr_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_instr_decoder -f sources.f \
  --Mdir obj_dir -o sim_tb > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
